/* hw/issue_pkg.sv */
// shared sizes and types for the long-instruction issue path
package issue_pkg;

    // architectural register address, x0..x31
    localparam int unsigned REG_ADDR_W = 5;

    // scoreboard depth and commit id width
    localparam int unsigned NUM_SLOTS = 8;
    localparam int unsigned SLOT_ID_W = 3;   // log2 of NUM_SLOTS

    // execution unit that runs a long instruction
    typedef enum logic [1:0] {
        EXU_ALU = 2'd0,
        EXU_MUL = 2'd1,
        EXU_DIV = 2'd2
    } exu_type_e;

    // fixed unit latencies in cycles
    // div latency is a module parameter, it varies per build
    localparam int unsigned ALU_CYCLES = 1;
    localparam int unsigned MUL_CYCLES = 3;

endpackage

/* hw/long_hazard_unit.sv */
`timescale 1ns/100ps

// scoreboard for in-flight long instructions
// raw and waw checks, lowest-free slot allocation, alu forwarding flags
module long_hazard_unit (
    input  logic                             clk,
    input  logic                             rst_n,
    // decoded instruction
    input  logic                             inst_valid_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                             rd_we_i,
    input  logic                             rs1_re_i,
    input  logic                             rs2_re_i,
    input  issue_pkg::exu_type_e             exu_type_i,
    // commit from the tracker
    input  logic                             commit_valid_i,
    input  logic [issue_pkg::SLOT_ID_W-1:0]  commit_id_i,
    // issue control
    output logic                             stall_o,
    output logic                             issue_fire_o,
    output logic [issue_pkg::SLOT_ID_W-1:0]  issue_id_o,
    output logic                             atom_lock_o,
    output logic                             alu_pass_op1_o,
    output logic                             alu_pass_op2_o
);
    import issue_pkg::*;

    // slot state
    logic [NUM_SLOTS-1:0]  slot_valid_q;            // slot holds an in-flight instruction
    logic [NUM_SLOTS-1:0]  slot_we_q;               // slot writes its rd
    logic [REG_ADDR_W-1:0] slot_rd_q   [NUM_SLOTS];
    exu_type_e             slot_type_q [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  alu_mask_q;              // one-hot newest alu writer, zero if none

    // per-slot check vectors
    logic [NUM_SLOTS-1:0]  commit_hit;              // slot retiring this cycle
    logic [NUM_SLOTS-1:0]  live;                    // valid and not retiring
    logic [NUM_SLOTS-1:0]  raw1_vec;
    logic [NUM_SLOTS-1:0]  raw2_vec;
    logic [NUM_SLOTS-1:0]  waw_vec;
    logic [NUM_SLOTS-1:0]  raw_block;               // raw hits that really stall
    logic [NUM_SLOTS-1:0]  issue_hit;               // slot filled at next edge

    logic                  is_alu;
    logic                  hazard;
    logic                  full;
    logic [SLOT_ID_W-1:0]  free_id;

    assign is_alu     = (exu_type_i == EXU_ALU);
    assign commit_hit = commit_valid_i ? (NUM_SLOTS'(1) << commit_id_i) : '0;
    assign live       = slot_valid_q & ~commit_hit;   // a commit frees its slot right away

    // compare against every live slot
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            raw1_vec[i] = live[i] && slot_we_q[i] && rs1_re_i && (rs1_addr_i == slot_rd_q[i]);
            raw2_vec[i] = live[i] && slot_we_q[i] && rs2_re_i && (rs2_addr_i == slot_rd_q[i]);
            // same unit keeps order by itself, only mixed units conflict
            waw_vec[i]  = live[i] && slot_we_q[i] && rd_we_i &&
                          (rd_addr_i == slot_rd_q[i]) && (exu_type_i != slot_type_q[i]);
        end
    end

    // alu reader may take the newest alu result by forwarding
    assign raw_block = is_alu ? ((raw1_vec | raw2_vec) & ~alu_mask_q) : (raw1_vec | raw2_vec);

    assign hazard = (|raw_block) || (|waw_vec);
    assign full   = &live;

    // lowest free slot, 0 when none
    always_comb begin
        free_id = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!live[i]) begin
                free_id = SLOT_ID_W'(i);
            end
        end
    end

    assign stall_o      = inst_valid_i && (hazard || full);
    assign issue_fire_o = inst_valid_i && !stall_o;
    assign issue_id_o   = free_id;
    assign issue_hit    = issue_fire_o ? (NUM_SLOTS'(1) << free_id) : '0;
    assign atom_lock_o  = |slot_valid_q;

    // pass flags only for an accepted alu instruction
    assign alu_pass_op1_o = issue_fire_o && is_alu && (|(raw1_vec & alu_mask_q));
    assign alu_pass_op2_o = issue_fire_o && is_alu && (|(raw2_vec & alu_mask_q));

    // valid bits, issue wins over commit on the same slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid_q <= '0;
        end else begin
            slot_valid_q <= (slot_valid_q & ~commit_hit) | issue_hit;
        end
    end

    // newest alu writer tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_mask_q <= '0;
        end else if (issue_fire_o && is_alu && rd_we_i) begin
            alu_mask_q <= issue_hit;             // newer writer replaces older one
        end else if (|(alu_mask_q & commit_hit)) begin
            alu_mask_q <= '0;                    // its result left the pipe
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (issue_fire_o) begin
            slot_we_q[free_id]   <= rd_we_i;
            slot_rd_q[free_id]   <= rd_addr_i;
            slot_type_q[free_id] <= exu_type_i;
        end
    end

    // tracker must only retire what this scoreboard holds
    a_commit_live: assert property (
        @(posedge clk) disable iff (!rst_n)
        commit_valid_i |-> slot_valid_q[commit_id_i]
    ) else $error("commit of empty slot %0d", commit_id_i);

    // allocated slot is empty or retiring, so a full scoreboard never fires
    a_no_fire_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_fire_o |-> !live[issue_id_o]
    ) else $error("issue into occupied slot %0d", issue_id_o);

endmodule

/* hw/long_exec_tracker.sv */
`timescale 1ns/100ps

// latency model for alu, mul and div units
// one countdown per slot, one commit per cycle, lowest ready slot first
module long_exec_tracker #(
    parameter int unsigned DIV_CYCLES = 6       // 2..15
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // issue from the hazard unit
    input  logic                             issue_fire_i,
    input  logic [issue_pkg::SLOT_ID_W-1:0]  issue_id_i,
    input  issue_pkg::exu_type_e             issue_type_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] issue_rd_i,
    // commit
    output logic                             commit_valid_o,
    output logic [issue_pkg::SLOT_ID_W-1:0]  commit_id_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] commit_rd_o
);
    import issue_pkg::*;

    localparam int unsigned CNT_W = 4;          // holds latencies up to 15

    logic [NUM_SLOTS-1:0]  busy_q;              // slot executing or waiting to commit
    logic [CNT_W-1:0]      cnt_q [NUM_SLOTS];   // cycles left until ready
    logic [REG_ADDR_W-1:0] rd_q  [NUM_SLOTS];   // rd returned with the commit

    logic [NUM_SLOTS-1:0]  ready;
    logic [NUM_SLOTS-1:0]  commit_hit;
    logic [NUM_SLOTS-1:0]  issue_hit;
    logic [CNT_W-1:0]      load_cnt;

    // latency of the unit that runs the instruction
    function automatic logic [CNT_W-1:0] unit_latency(input exu_type_e t);
        logic [CNT_W-1:0] lat;
        case (t)
            EXU_ALU: lat = CNT_W'(ALU_CYCLES);
            EXU_MUL: lat = CNT_W'(MUL_CYCLES);
            EXU_DIV: lat = CNT_W'(DIV_CYCLES);
            default: lat = CNT_W'(ALU_CYCLES);  // unused code
        endcase
        return lat;
    endfunction

    assign load_cnt  = unit_latency(issue_type_i);
    assign issue_hit = issue_fire_i ? (NUM_SLOTS'(1) << issue_id_i) : '0;

    // ready once the countdown has run out
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            ready[i] = busy_q[i] && (cnt_q[i] == '0);
        end
    end

    // lowest ready slot wins
    always_comb begin
        commit_id_o = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                commit_id_o = SLOT_ID_W'(i);
            end
        end
    end

    assign commit_valid_o = |ready;
    assign commit_rd_o    = rd_q[commit_id_o];
    assign commit_hit     = commit_valid_o ? (NUM_SLOTS'(1) << commit_id_o) : '0;

    // busy bits, a new issue may reuse the slot committing now
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q & ~commit_hit) | issue_hit;
        end
    end

    // countdown, holds at zero while the slot waits its turn
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (issue_hit[i]) begin
                    cnt_q[i] <= load_cnt;
                end else if (cnt_q[i] != '0) begin
                    cnt_q[i] <= cnt_q[i] - 1'b1;
                end
            end
        end
    end

    // rd tag per slot
    always_ff @(posedge clk) begin
        if (issue_fire_i) begin
            rd_q[issue_id_i] <= issue_rd_i;
        end
    end

    // hazard unit allocation must match tracker occupancy
    a_load_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        issue_fire_i |-> (!busy_q[issue_id_i] || commit_hit[issue_id_i])
    ) else $error("issue into busy slot %0d", issue_id_i);

endmodule

/* hw/long_issue_top.sv */
`timescale 1ns/100ps

// long-instruction issue subsystem
// hazard unit gates decode, tracker returns commits
module long_issue_top #(
    parameter int unsigned DIV_CYCLES = 6       // div unit latency, 2..15
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // decode
    input  logic                             inst_valid_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                             rd_we_i,
    input  logic                             rs1_re_i,
    input  logic                             rs2_re_i,
    input  issue_pkg::exu_type_e             exu_type_i,
    // issue status
    output logic                             stall_o,
    output logic [issue_pkg::SLOT_ID_W-1:0]  issue_id_o,
    output logic                             atom_lock_o,
    output logic                             alu_pass_op1_o,
    output logic                             alu_pass_op2_o,
    // commit
    output logic                             commit_valid_o,
    output logic [issue_pkg::SLOT_ID_W-1:0]  commit_id_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] commit_rd_o
);

    logic issue_fire;                           // accepted instruction this cycle

    long_hazard_unit u_hazard (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .rd_addr_i      (rd_addr_i),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rd_we_i        (rd_we_i),
        .rs1_re_i       (rs1_re_i),
        .rs2_re_i       (rs2_re_i),
        .exu_type_i     (exu_type_i),
        .commit_valid_i (commit_valid_o),       // commit frees the slot same cycle
        .commit_id_i    (commit_id_o),
        .stall_o        (stall_o),
        .issue_fire_o   (issue_fire),
        .issue_id_o     (issue_id_o),
        .atom_lock_o    (atom_lock_o),
        .alu_pass_op1_o (alu_pass_op1_o),
        .alu_pass_op2_o (alu_pass_op2_o)
    );

    long_exec_tracker #(
        .DIV_CYCLES (DIV_CYCLES)
    ) u_tracker (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_fire_i   (issue_fire),
        .issue_id_i     (issue_id_o),
        .issue_type_i   (exu_type_i),           // unit type straight from decode
        .issue_rd_i     (rd_addr_i),
        .commit_valid_o (commit_valid_o),
        .commit_id_o    (commit_id_o),
        .commit_rd_o    (commit_rd_o)
    );

endmodule

/* verification/tb_long_issue.sv */
`timescale 1ns/100ps

module tb_long_issue;
    import issue_pkg::*;

    localparam int unsigned WAIT_LIMIT = 100;   // cycles per wait loop

    // one stimulus row, -1 in an int field means not checked or no wait
    typedef struct {
        logic      valid;
        exu_type_e typ;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic      we;
        logic      re1;
        logic      re2;
        int        wait_id;                 // hold row until this id commits
        logic      exp_stall;
        int        exp_id;
        logic      exp_p1;
        logic      exp_p2;
        int        exp_lock;
    } row_t;

    logic clk;
    logic rst_n;
    logic inst_valid_i;
    logic [REG_ADDR_W-1:0] rd_addr_i;
    logic [REG_ADDR_W-1:0] rs1_addr_i;
    logic [REG_ADDR_W-1:0] rs2_addr_i;
    logic rd_we_i;
    logic rs1_re_i;
    logic rs2_re_i;
    exu_type_e exu_type_i;
    logic stall_o;
    logic [SLOT_ID_W-1:0] issue_id_o;
    logic atom_lock_o;
    logic alu_pass_op1_o;
    logic alu_pass_op2_o;
    logic commit_valid_o;
    logic [SLOT_ID_W-1:0] commit_id_o;
    logic [REG_ADDR_W-1:0] commit_rd_o;

    row_t table_q[$];
    bit   pending [NUM_SLOTS];                  // model of occupied slots
    logic [REG_ADDR_W-1:0] model_rd [NUM_SLOTS];
    int   commit_log[$];
    int   issued_cnt;

    // longest div latency so all eight slots can be occupied at once
    long_issue_top #(
        .DIV_CYCLES (15)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid_i   (inst_valid_i),
        .rd_addr_i      (rd_addr_i),
        .rs1_addr_i     (rs1_addr_i),
        .rs2_addr_i     (rs2_addr_i),
        .rd_we_i        (rd_we_i),
        .rs1_re_i       (rs1_re_i),
        .rs2_re_i       (rs2_re_i),
        .exu_type_i     (exu_type_i),
        .stall_o        (stall_o),
        .issue_id_o     (issue_id_o),
        .atom_lock_o    (atom_lock_o),
        .alu_pass_op1_o (alu_pass_op1_o),
        .alu_pass_op2_o (alu_pass_op2_o),
        .commit_valid_o (commit_valid_o),
        .commit_id_o    (commit_id_o),
        .commit_rd_o    (commit_rd_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                  // 8 ns period
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic add_row(input logic valid, input exu_type_e typ, input int rd, input int rs1,
                           input int rs2, input logic re1, input logic re2, input int wait_id,
                           input logic stall, input int id, input logic p1, input logic p2,
                           input int lock);
        row_t r;
        r.valid = valid;
        r.typ = typ;
        r.rd = rd[REG_ADDR_W-1:0];
        r.rs1 = rs1[REG_ADDR_W-1:0];
        r.rs2 = rs2[REG_ADDR_W-1:0];
        r.we = valid;                           // every instruction here writes rd
        r.re1 = re1;
        r.re2 = re2;
        r.wait_id = wait_id;
        r.exp_stall = stall;
        r.exp_id = id;
        r.exp_p1 = p1;
        r.exp_p2 = p2;
        r.exp_lock = lock;
        table_q.push_back(r);
    endtask

    // commit monitor, outputs settle from flops well before falling edge
    always @(negedge clk) begin
        if (rst_n && commit_valid_o) begin
            if (!pending[commit_id_o]) begin
                stop_with_error($sformatf("commit of slot %0d that holds nothing", commit_id_o));
            end
            check("commit_rd_o", commit_rd_o, model_rd[commit_id_o]);
            pending[commit_id_o] = 1'b0;
            commit_log.push_back(commit_id_o);
        end
    end

    initial begin
        row_t r;
        int   n;
        bit   busy;
        inst_valid_i = 1'b0;
        rd_addr_i = '0;
        rs1_addr_i = '0;
        rs2_addr_i = '0;
        rd_we_i = 1'b0;
        rs1_re_i = 1'b0;
        rs2_re_i = 1'b0;
        exu_type_i = EXU_ALU;
        issued_cnt = 0;
        rst_n = 1'b0;

        // allocation, eight divs fill the scoreboard
        for (int k = 0; k < 8; k++) begin
            add_row(1, EXU_DIV, k + 1, 0, 0, 0, 0, -1, 0, k, 0, 0, (k == 0) ? 0 : 1);
        end
        add_row(1, EXU_DIV, 9, 0, 0, 0, 0, -1, 1, -1, 0, 0, 1);     // full
        add_row(1, EXU_DIV, 9, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1);       // freed slot 0
        add_row(0, EXU_ALU, 0, 0, 0, 0, 0, 0, 0, -1, 0, 0, -1);     // drain
        // raw on a div result
        add_row(1, EXU_DIV, 10, 0, 0, 0, 0, -1, 0, 0, 0, 0, 0);
        add_row(1, EXU_ALU, 11, 10, 0, 1, 0, -1, 1, -1, 0, 0, 1);
        add_row(1, EXU_ALU, 11, 10, 0, 1, 0, 0, 0, 0, 0, 0, 1);     // accepted at commit
        // alu forwarding from newest alu writer
        add_row(1, EXU_ALU, 12, 11, 11, 1, 1, -1, 0, 1, 1, 1, 1);
        add_row(1, EXU_MUL, 13, 12, 0, 1, 0, -1, 1, -1, 0, 0, 1);   // mul cannot forward
        add_row(1, EXU_MUL, 13, 12, 0, 1, 0, 1, 0, 0, 0, 0, -1);
        add_row(0, EXU_ALU, 0, 0, 0, 0, 0, 0, 0, -1, 0, 0, -1);
        // waw between units
        add_row(1, EXU_MUL, 5, 0, 0, 0, 0, -1, 0, 0, 0, 0, 0);
        add_row(1, EXU_ALU, 5, 0, 0, 0, 0, -1, 1, -1, 0, 0, 1);
        add_row(1, EXU_MUL, 5, 0, 0, 0, 0, -1, 0, 1, 0, 0, 1);     // same unit keeps order
        add_row(0, EXU_ALU, 0, 0, 0, 0, 0, 1, 0, -1, 0, 0, -1);
        // commit order, div then mul
        add_row(1, EXU_DIV, 20, 0, 0, 0, 0, -1, 0, 0, 0, 0, 0);
        add_row(1, EXU_MUL, 21, 0, 0, 0, 0, -1, 0, 1, 0, 0, 1);
        add_row(0, EXU_ALU, 0, 0, 0, 0, 0, 1, 0, -1, 0, 0, -1);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check("stall_o", stall_o, 0);
        check("commit_valid_o", commit_valid_o, 0);
        check("atom_lock_o", atom_lock_o, 0);
        check("alu_pass_op1_o", alu_pass_op1_o, 0);
        check("alu_pass_op2_o", alu_pass_op2_o, 0);
        check("issue_id_o", issue_id_o, 0);

        foreach (table_q[i]) begin
            r = table_q[i];
            @(negedge clk);
            inst_valid_i = r.valid;
            exu_type_i = r.typ;
            rd_addr_i = r.rd;
            rs1_addr_i = r.rs1;
            rs2_addr_i = r.rs2;
            rd_we_i = r.we;
            rs1_re_i = r.re1;
            rs2_re_i = r.re2;
            #1;
            if (r.wait_id >= 0) begin
                n = 0;
                while (!(commit_valid_o && commit_id_o == r.wait_id)) begin
                    n++;
                    if (n > WAIT_LIMIT) begin
                        stop_with_error($sformatf("timeout waiting for commit of id %0d in row %0d",
                                                  r.wait_id, i));
                    end
                    @(negedge clk);
                    #1;
                end
            end
            check("stall_o", stall_o, r.exp_stall);
            if (r.exp_id >= 0) check("issue_id_o", issue_id_o, r.exp_id);
            check("alu_pass_op1_o", alu_pass_op1_o, r.exp_p1);
            check("alu_pass_op2_o", alu_pass_op2_o, r.exp_p2);
            if (r.exp_lock >= 0) check("atom_lock_o", atom_lock_o, r.exp_lock);
            // record accepted instruction in the model
            if (r.valid && !r.exp_stall) begin
                if (pending[r.exp_id]) begin
                    stop_with_error($sformatf("slot %0d issued twice without commit", r.exp_id));
                end
                pending[r.exp_id] = 1'b1;
                model_rd[r.exp_id] = r.rd;
                issued_cnt++;
            end
        end

        @(negedge clk);
        inst_valid_i = 1'b0;
        #1;
        n = 0;
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            foreach (pending[s]) busy |= pending[s];
            if (busy) begin
                n++;
                if (n > WAIT_LIMIT) begin
                    stop_with_error("timeout waiting for the last commits to drain");
                end
                @(negedge clk);
                #1;
            end
        end

        check("commit count", commit_log.size(), issued_cnt);
        check("mul commit id", commit_log[commit_log.size() - 2], 1);  // mul overtakes div
        check("div commit id", commit_log[commit_log.size() - 1], 0);
        @(negedge clk);                         // last commit clears its slot at the next edge
        #1;
        check("atom_lock_o", atom_lock_o, 0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* verilog.f */
hw/issue_pkg.sv
hw/long_hazard_unit.sv
hw/long_exec_tracker.sv
hw/long_issue_top.sv
verification/tb_long_issue.sv

/* Bender.yml */
package:
  name: long_issue

sources:
  - hw/issue_pkg.sv
  - hw/long_hazard_unit.sv
  - hw/long_exec_tracker.sv
  - hw/long_issue_top.sv
  - target: test
    files:
      - verification/tb_long_issue.sv
